// File: hw/axi_mem_pkg.sv
package axi_mem_pkg;

    // address map
    localparam logic [31:0] flash_base  = 32'h3000_0000;
    localparam int          flash_words = 1024;
    localparam logic [31:0] sdram_base  = 32'ha000_0000;
    localparam int          sdram_words = 1024;
    localparam logic [31:0] uart_base   = 32'h1000_0000;
    // offset 0 is tx data, offset 4 is the sent count
    localparam int          uart_bytes  = 8;

    // word index wide enough for the deeper bank
    localparam int index_w = $clog2(flash_words > sdram_words ? flash_words : sdram_words);

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_decerr = 2'd3;

    typedef enum logic [1:0] {
        region_flash,
        region_sdram,
        region_uart,
        region_none
    } region_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
    } ar_chan_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } r_chan_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } aw_chan_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } w_chan_t;

    typedef struct packed {
        logic [1:0] resp;
    } b_chan_t;

    typedef struct packed {
        logic               we;
        logic [index_w-1:0] index;
        logic [31:0]        data;
        logic [3:0]         strb;
    } mem_wr_t;

    typedef struct packed {
        logic               re;
        logic [index_w-1:0] index;
    } mem_rd_t;

endpackage

// File: hw/region_decoder.sv
`timescale 1ns/1ps

module region_decoder
    import axi_mem_pkg::*;
(
    input  logic [31:0]        addr,
    output region_t            region,
    output logic [index_w-1:0] index,
    output logic               uart_reg
);

    localparam logic [31:0] flash_top = flash_base + 32'(flash_words * 4);
    localparam logic [31:0] sdram_top = sdram_base + 32'(sdram_words * 4);
    localparam logic [31:0] uart_top  = uart_base + 32'(uart_bytes);

    logic [31:0] offset;

    always_comb begin
        region = region_none;
        offset = '0;
        if (addr >= flash_base && addr < flash_top) begin
            region = region_flash;
            offset = addr - flash_base;
        end else if (addr >= sdram_base && addr < sdram_top) begin
            region = region_sdram;
            offset = addr - sdram_base;
        end else if (addr >= uart_base && addr < uart_top) begin
            region = region_uart;
            offset = addr - uart_base;
        end
    end

    // byte offset to word index
    assign index = (region == region_uart) ? '0 : offset[index_w+1:2];

    // second word of the uart window is the count register
    assign uart_reg = (region == region_uart) && offset[2];

endmodule

// File: hw/mem_bank.sv
`timescale 1ns/1ps

module mem_bank
    import axi_mem_pkg::*;
#(
    parameter int depth = flash_words
) (
    input  logic        clock,
    input  mem_rd_t     rd,
    output logic [31:0] rdata,
    input  mem_wr_t     wr
);

    logic [31:0] mem [depth];

    // registered read holds its word until the next request
    always_ff @(posedge clock) begin
        if (rd.re) begin
            rdata <= mem[rd.index];
        end
    end

    // byte lane merge under strobe
    always_ff @(posedge clock) begin
        if (wr.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wr.strb[lane]) begin
                    mem[wr.index][lane*8 +: 8] <= wr.data[lane*8 +: 8];
                end
            end
        end
    end

    // decoder ranges must keep both ports inside the array
    a_rd_index: assert property (
        @(posedge clock) rd.re |-> (int'(rd.index) < depth)
    );

    a_wr_index: assert property (
        @(posedge clock) wr.we |-> (int'(wr.index) < depth)
    );

endmodule

// File: hw/uart_sink.sv
`timescale 1ns/1ps

module uart_sink (
    input  logic        clock,
    input  logic        rst,
    input  logic        we,
    input  logic        reg_sel,
    input  logic [7:0]  wdata,
    output logic        uart_valid,
    output logic [7:0]  uart_char,
    output logic [31:0] uart_count
);

    // strobe and sent count
    always_ff @(posedge clock) begin
        if (rst) begin
            uart_valid <= 1'b0;
            uart_count <= '0;
        end else begin
            uart_valid <= we && !reg_sel;
            if (we && reg_sel) begin
                uart_count <= '0;
            end else if (we) begin
                uart_count <= uart_count + 32'd1;
            end
        end
    end

    // low byte of the latest data register write
    always_ff @(posedge clock) begin
        if (we && !reg_sel) begin
            uart_char <= wdata;
        end
    end

    // the write engine spends at least a resp cycle between commits
    a_single_strobe: assert property (
        @(posedge clock) disable iff (rst)
        uart_valid |=> !uart_valid
    );

endmodule

// File: hw/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine
    import axi_mem_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        ar_valid,
    output logic        ar_ready,
    input  ar_chan_t    ar,
    output logic        r_valid,
    input  logic        r_ready,
    output r_chan_t     r,
    output mem_rd_t     flash_rd,
    input  logic [31:0] flash_rdata,
    output mem_rd_t     sdram_rd,
    input  logic [31:0] sdram_rdata,
    input  logic [31:0] uart_count
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_data
    } state_t;

    state_t             state;
    logic               issued;
    logic [31:0]        addr_q;
    logic [7:0]         len_q;
    logic [7:0]         beat_q;
    region_t            region;
    logic [index_w-1:0] index;
    logic               uart_reg;
    logic               issue;
    r_chan_t            r_next;

    region_decoder i_region_decoder (
        .addr     (addr_q),
        .region   (region),
        .index    (index),
        .uart_reg (uart_reg)
    );

    // first fetch cycle sends the request, second one sees the bank word
    assign issue = (state == st_fetch) && !issued;

    always_comb begin
        flash_rd.re    = issue && (region == region_flash);
        flash_rd.index = index;
        sdram_rd.re    = issue && (region == region_sdram);
        sdram_rd.index = index;
    end

    // beat data source
    always_comb begin
        r_next.data = '0;
        r_next.resp = resp_okay;
        r_next.last = (beat_q == len_q);
        case (region)
            region_flash: r_next.data = flash_rdata;
            region_sdram: r_next.data = sdram_rdata;
            region_uart: begin
                if (uart_reg) begin
                    r_next.data = uart_count;
                end
            end
            default: r_next.resp = resp_decerr;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state  <= st_idle;
            issued <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (ar_valid) begin
                        state  <= st_fetch;
                        issued <= 1'b0;
                    end
                end
                st_fetch: begin
                    if (!issued) begin
                        issued <= 1'b1;
                    end else begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (r_ready) begin
                        state  <= r.last ? st_idle : st_fetch;
                        issued <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // burst address, beat count and the r register
    always_ff @(posedge clock) begin
        if (state == st_idle && ar_valid) begin
            addr_q <= ar.addr;
            len_q  <= ar.len;
            beat_q <= '0;
        end
        if (state == st_fetch && issued) begin
            r <= r_next;
        end
        if (state == st_data && r_ready && !r.last) begin
            addr_q <= addr_q + 32'd4;
            beat_q <= beat_q + 8'd1;
        end
    end

    assign ar_ready = (state == st_idle);
    assign r_valid  = (state == st_data);

    a_r_stable: assert property (
        @(posedge clock) disable iff (rst)
        (r_valid && !r_ready) |=> (r_valid && $stable(r))
    );

endmodule

// File: hw/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine
    import axi_mem_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  aw_chan_t   aw,
    input  logic       w_valid,
    output logic       w_ready,
    input  w_chan_t    w,
    output logic       b_valid,
    input  logic       b_ready,
    output b_chan_t    b,
    output mem_wr_t    flash_wr,
    output mem_wr_t    sdram_wr,
    output logic       uart_we,
    output logic       uart_reg,
    output logic [7:0] uart_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_commit,
        st_resp
    } state_t;

    state_t             state;
    logic               aw_held;
    logic               w_held;
    logic [31:0]        aw_addr;
    w_chan_t            w_q;
    logic               aw_hs;
    logic               w_hs;
    logic               commit;
    region_t            region;
    logic [index_w-1:0] index;

    region_decoder i_region_decoder (
        .addr     (aw_addr),
        .region   (region),
        .index    (index),
        .uart_reg (uart_reg)
    );

    // each channel closes once its beat is held
    assign aw_ready = !aw_held;
    assign w_ready  = !w_held;
    assign aw_hs    = aw_valid && aw_ready;
    assign w_hs     = w_valid && w_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= st_idle;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_hs) begin
                        aw_held <= 1'b1;
                    end
                    if (w_hs) begin
                        w_held <= 1'b1;
                    end
                    // go as soon as the later of the two lands
                    if ((aw_held || aw_hs) && (w_held || w_hs)) begin
                        state <= st_commit;
                    end
                end
                st_commit: state <= st_resp;
                st_resp: begin
                    if (b_ready) begin
                        state   <= st_idle;
                        aw_held <= 1'b0;
                        w_held  <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            aw_addr <= aw.addr;
        end
        if (w_hs) begin
            w_q <= w;
        end
    end

    assign commit = (state == st_commit);

    // at most one target sees we, none on a decode miss
    always_comb begin
        flash_wr.we    = commit && (region == region_flash);
        flash_wr.index = index;
        flash_wr.data  = w_q.data;
        flash_wr.strb  = w_q.strb;
        sdram_wr.we    = commit && (region == region_sdram);
        sdram_wr.index = index;
        sdram_wr.data  = w_q.data;
        sdram_wr.strb  = w_q.strb;
    end

    assign uart_we   = commit && (region == region_uart);
    assign uart_data = w_q.data[7:0];

    assign b_valid = (state == st_resp);
    assign b.resp  = (region == region_none) ? resp_decerr : resp_okay;

    a_aw_single: assert property (
        @(posedge clock) disable iff (rst)
        aw_hs |-> (aw.len == 8'd0 && aw.size == 3'd2)
    );

    a_w_last: assert property (
        @(posedge clock) disable iff (rst)
        w_hs |-> w.last
    );

endmodule

// File: hw/axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top
    import axi_mem_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       ar_valid,
    output logic       ar_ready,
    input  ar_chan_t   ar,
    output logic       r_valid,
    input  logic       r_ready,
    output r_chan_t    r,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  aw_chan_t   aw,
    input  logic       w_valid,
    output logic       w_ready,
    input  w_chan_t    w,
    output logic       b_valid,
    input  logic       b_ready,
    output b_chan_t    b,
    output logic       uart_valid,
    output logic [7:0] uart_char
);

    mem_rd_t     flash_rd;
    mem_rd_t     sdram_rd;
    mem_wr_t     flash_wr;
    mem_wr_t     sdram_wr;
    logic [31:0] flash_rdata;
    logic [31:0] sdram_rdata;
    logic        uart_we;
    logic        uart_reg;
    logic [7:0]  uart_data;
    logic [31:0] uart_count;

    axi_read_engine i_axi_read_engine (
        .clock       (clock),
        .rst         (rst),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar          (ar),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r           (r),
        .flash_rd    (flash_rd),
        .flash_rdata (flash_rdata),
        .sdram_rd    (sdram_rd),
        .sdram_rdata (sdram_rdata),
        .uart_count  (uart_count)
    );

    axi_write_engine i_axi_write_engine (
        .clock     (clock),
        .rst       (rst),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b         (b),
        .flash_wr  (flash_wr),
        .sdram_wr  (sdram_wr),
        .uart_we   (uart_we),
        .uart_reg  (uart_reg),
        .uart_data (uart_data)
    );

    // separate read and write ports, so the engines never contend
    mem_bank #(.depth(flash_words)) flash_bank (
        .clock (clock),
        .rd    (flash_rd),
        .rdata (flash_rdata),
        .wr    (flash_wr)
    );

    mem_bank #(.depth(sdram_words)) sdram_bank (
        .clock (clock),
        .rd    (sdram_rd),
        .rdata (sdram_rdata),
        .wr    (sdram_wr)
    );

    uart_sink i_uart_sink (
        .clock      (clock),
        .rst        (rst),
        .we         (uart_we),
        .reg_sel    (uart_reg),
        .wdata      (uart_data),
        .uart_valid (uart_valid),
        .uart_char  (uart_char),
        .uart_count (uart_count)
    );

endmodule

// File: test/tb_axi_mem_tasks.svh
task automatic check_value(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
    if (actual !== expected) begin
        errors++;
        $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
    end
endtask

// each sender is entered 1 ns after an edge and returns 1 ns after its handshake edge
task automatic send_ar(input logic [31:0] addr, input logic [7:0] len);
    logic hs;
    ar_valid = 1'b1;
    ar.addr  = addr;
    ar.len   = len;
    do begin
        hs = ar_ready;
        @(posedge clock);
        #1;
    end while (!hs);
    ar_valid = 1'b0;
endtask

task automatic send_aw(input logic [31:0] addr);
    logic hs;
    aw_valid = 1'b1;
    aw.addr  = addr;
    aw.len   = 8'd0;
    aw.size  = 3'd2;
    do begin
        hs = aw_ready;
        @(posedge clock);
        #1;
    end while (!hs);
    aw_valid = 1'b0;
endtask

task automatic send_w(input logic [31:0] data, input logic [3:0] strb);
    logic hs;
    w_valid = 1'b1;
    w.data  = data;
    w.strb  = strb;
    w.last  = 1'b1;
    do begin
        hs = w_ready;
        @(posedge clock);
        #1;
    end while (!hs);
    w_valid = 1'b0;
endtask

task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
        input logic [3:0] strb, input logic aw_first, input logic stall,
        output logic [1:0] resp);
    logic hs;
    resp = 2'd0;
    if (aw_first) begin
        send_aw(addr);
        send_w(data, strb);
    end else begin
        send_w(data, strb);
        send_aw(addr);
    end
    do begin
        b_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
        hs = b_valid && b_ready;
        if (hs) begin
            resp = b.resp;
        end
        @(posedge clock);
        #1;
    end while (!hs);
    b_ready = 1'b0;
endtask

// beats land in rd_data, rd_resp and rd_last
task automatic axi_read_burst(input logic [31:0] addr, input logic [7:0] len,
        input logic stall);
    logic    hs;
    logic    stalled;
    logic    done;
    r_chan_t held;
    rd_data.delete();
    rd_resp.delete();
    rd_last.delete();
    send_ar(addr, len);
    done = 1'b0;
    while (!done) begin
        r_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
        hs = r_valid && r_ready;
        if (hs) begin
            rd_data.push_back(r.data);
            rd_resp.push_back(r.resp);
            rd_last.push_back(r.last);
            // stop on last, or once the expected count is in
            done = r.last || (rd_data.size() == int'(len) + 1);
        end
        stalled = r_valid && !r_ready;
        held = r;
        @(posedge clock);
        #1;
        if (stalled) begin
            check_value("r valid hold", 32'd1, 32'(r_valid));
            check_value("r data hold", held.data, r.data);
            check_value("r resp last hold", 32'({held.resp, held.last}),
                32'({r.resp, r.last}));
        end
    end
    r_ready = 1'b0;
endtask

// File: test/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem
    import axi_mem_pkg::*;
();

    localparam int fill_flash = 16;
    localparam int fill_sdram = 64;
    localparam int n_partial  = 8;
    localparam int n_bursts   = 4;
    localparam int max_burst  = 16;
    localparam int n_chars    = 5;
    // every write and read beat of all tests, stalled repeats included
    localparam int total_beats = 2 * (fill_flash + fill_sdram) + 4 * n_partial
        + 2 * n_bursts * max_burst + 2 * n_chars + 16;
    localparam int timeout_ns = total_beats * 20 * 4 + 2000;

    logic       clock;
    logic       rst;
    logic       ar_valid;
    logic       ar_ready;
    ar_chan_t   ar;
    logic       r_valid;
    logic       r_ready;
    r_chan_t    r;
    logic       aw_valid;
    logic       aw_ready;
    aw_chan_t   aw;
    logic       w_valid;
    logic       w_ready;
    w_chan_t    w;
    logic       b_valid;
    logic       b_ready;
    b_chan_t    b;
    logic       uart_valid;
    logic [7:0] uart_char;

    integer      seed = 58789;
    int          errors;
    int          mark;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] flash_shadow [flash_words];
    logic [31:0] sdram_shadow [sdram_words];
    logic [31:0] rd_data[$];
    logic [1:0]  rd_resp[$];
    logic        rd_last[$];
    logic [7:0]  expected_chars[$];

    `include "tb_axi_mem_tasks.svh"

    axi_mem_top i_axi_mem_top (
        .clock      (clock),
        .rst        (rst),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar         (ar),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r          (r),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw         (aw),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w          (w),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .b          (b),
        .uart_valid (uart_valid),
        .uart_char  (uart_char)
    );

    always #2 clock = ~clock;

    // strobed bytes take the new data, the rest keep the old word
    function automatic logic [31:0] merge_word(input logic [31:0] old_word,
            input logic [31:0] new_word, input logic [3:0] strb);
        logic [31:0] merged;
        merged = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                merged[lane*8 +: 8] = new_word[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic logic [31:0] fill_value(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5ac3_0f0f;
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] addr);
        if (addr >= flash_base && addr < flash_base + 32'(flash_words * 4)) begin
            return flash_shadow[int'((addr - flash_base) >> 2)];
        end else if (addr >= sdram_base && addr < sdram_base + 32'(sdram_words * 4)) begin
            return sdram_shadow[int'((addr - sdram_base) >> 2)];
        end
        return 32'd0;
    endfunction

    task automatic track_write(input logic [31:0] addr, input logic [31:0] data,
            input logic [3:0] strb);
        int idx;
        if (addr >= flash_base && addr < flash_base + 32'(flash_words * 4)) begin
            idx = int'((addr - flash_base) >> 2);
            flash_shadow[idx] = merge_word(flash_shadow[idx], data, strb);
        end else if (addr >= sdram_base && addr < sdram_base + 32'(sdram_words * 4)) begin
            idx = int'((addr - sdram_base) >> 2);
            sdram_shadow[idx] = merge_word(sdram_shadow[idx], data, strb);
        end
    endtask

    task automatic write_word(input string name, input logic [31:0] addr,
            input logic [31:0] data, input logic [3:0] strb, input logic aw_first,
            input logic stall, input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, strb, aw_first, stall, resp);
        check_value({name, " bresp"}, 32'(exp_resp), 32'(resp));
        if (exp_resp == resp_okay) begin
            track_write(addr, data, strb);
        end
    endtask

    task automatic read_and_compare(input string name, input logic [31:0] addr,
            input logic [7:0] len, input logic stall);
        axi_read_burst(addr, len, stall);
        check_value({name, " beats"}, 32'(len) + 32'd1, 32'(rd_data.size()));
        for (int i = 0; i < rd_data.size(); i++) begin
            check_value({name, " data"}, shadow_read(addr + 32'(i * 4)), rd_data[i]);
            check_value({name, " resp"}, 32'(resp_okay), 32'(rd_resp[i]));
            check_value({name, " last"}, 32'(i == int'(len)), 32'(rd_last[i]));
        end
    endtask

    task automatic read_word(input string name, input logic [31:0] addr,
            output logic [31:0] data, output logic [1:0] resp);
        axi_read_burst(addr, 8'd0, 1'b0);
        check_value({name, " beats"}, 32'd1, 32'(rd_data.size()));
        data = '0;
        resp = '0;
        if (rd_data.size() > 0) begin
            data = rd_data[0];
            resp = rd_resp[0];
            check_value({name, " last"}, 32'd1, 32'(rd_last[0]));
        end
    endtask

    // each partial write is read straight back
    task automatic run_partial(input logic stall);
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        int          idx;
        for (int i = 0; i < n_partial; i++) begin
            if (i[0]) begin
                idx = int'($unsigned($random(seed)) % fill_sdram);
                addr = sdram_base + 32'(idx * 4);
            end else begin
                idx = int'($unsigned($random(seed)) % fill_flash);
                addr = flash_base + 32'(idx * 4);
            end
            data = $random(seed);
            strb = 4'($random(seed));
            if (strb == 4'h0 || strb == 4'hf) begin
                strb = 4'b0101;
            end
            write_word("partial write", addr, data, strb, i[1], stall, resp_okay);
            read_and_compare("partial read", addr, 8'd0, stall);
        end
    endtask

    task automatic run_bursts(input logic stall);
        int         start;
        logic [7:0] len;
        for (int i = 0; i < n_bursts; i++) begin
            len = 8'($random(seed) & 15);
            start = int'($unsigned($random(seed)) % (fill_sdram - max_burst));
            read_and_compare("burst", sdram_base + 32'(start * 4), len, stall);
        end
    endtask

    task automatic report_test(input string name);
        if (errors == mark) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d mismatches", name, errors - mark);
        end
        mark = errors;
    endtask

    // each strobe must carry the next expected byte
    always @(negedge clock) begin
        if (!rst && uart_valid) begin
            if (expected_chars.size() == 0) begin
                errors++;
                $display("uart strobe with no character expected, got %02h", uart_char);
            end else begin
                check_value("uart char", 32'(expected_chars.pop_front()), 32'(uart_char));
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("timeout: run did not finish within %0d ns", timeout_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  resp;
        clock    = 1'b0;
        rst      = 1'b1;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b0;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        errors   = 0;
        mark     = 0;
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;

        check_value("reset ready", 32'h7, {29'd0, ar_ready, aw_ready, w_ready});
        check_value("reset valid", 32'h0, {29'd0, r_valid, b_valid, uart_valid});
        for (int i = 0; i < fill_flash; i++) begin
            addr = flash_base + 32'(i * 4);
            write_word("flash fill", addr, fill_value(addr), 4'hf, i[0], 1'b0, resp_okay);
        end
        for (int i = 0; i < fill_sdram; i++) begin
            addr = sdram_base + 32'(i * 4);
            write_word("sdram fill", addr, fill_value(addr), 4'hf, i[0], 1'b0, resp_okay);
        end
        for (int i = 0; i < fill_flash; i++) begin
            read_and_compare("flash read", flash_base + 32'(i * 4), 8'd0, 1'b0);
        end
        for (int i = 0; i < fill_sdram; i += 8) begin
            read_and_compare("sdram read", sdram_base + 32'(i * 4), 8'd0, 1'b0);
        end
        report_test("full_word");

        run_partial(1'b0);
        report_test("partial");
        run_bursts(1'b0);
        report_test("burst");

        write_word("uart clear", uart_base + 32'd4, 32'd0, 4'hf, 1'b1, 1'b0, resp_okay);
        for (int i = 0; i < n_chars; i++) begin
            data = $random(seed);
            expected_chars.push_back(data[7:0]);
            write_word("uart send", uart_base, data, 4'hf, i[0], 1'b0, resp_okay);
        end
        check_value("uart pending", 32'd0, 32'(expected_chars.size()));
        read_word("uart count", uart_base + 32'd4, data, resp);
        check_value("uart count resp", 32'(resp_okay), 32'(resp));
        check_value("uart count value", 32'(n_chars), data);
        write_word("uart clear", uart_base + 32'd4, 32'd0, 4'hf, 1'b0, 1'b0, resp_okay);
        read_word("uart count", uart_base + 32'd4, data, resp);
        check_value("uart count cleared resp", 32'(resp_okay), 32'(resp));
        check_value("uart count cleared", 32'd0, data);
        report_test("uart");

        read_word("decerr read", 32'h2000_0000, data, resp);
        check_value("decerr read resp", 32'(resp_decerr), 32'(resp));
        check_value("decerr read data", 32'd0, data);
        write_word("decerr write", 32'h2000_0000, 32'hdead_beef, 4'hf, 1'b1, 1'b0,
            resp_decerr);
        // one past each bank end would alias to word 0 if decoded
        write_word("decerr flash end", flash_base + 32'(flash_words * 4), 32'h1234_5678,
            4'hf, 1'b0, 1'b0, resp_decerr);
        write_word("decerr sdram end", sdram_base + 32'(sdram_words * 4), 32'h8765_4321,
            4'hf, 1'b1, 1'b0, resp_decerr);
        read_and_compare("decerr flash neighbour", flash_base, 8'd1, 1'b0);
        read_and_compare("decerr sdram neighbour", sdram_base, 8'd1, 1'b0);
        report_test("decerr");

        run_partial(1'b1);
        report_test("partial_stall");
        run_bursts(1'b1);
        report_test("burst_stall");

        $display("tests passed %0d, failed %0d, mismatches %0d",
            tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+test
hw/axi_mem_pkg.sv
hw/region_decoder.sv
hw/mem_bank.sv
hw/uart_sink.sv
hw/axi_read_engine.sv
hw/axi_write_engine.sv
hw/axi_mem_top.sv
test/tb_axi_mem.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_axi_mem -Mdir obj_dir
	./obj_dir/Vtb_axi_mem | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
